// ==== rtl/slam_cb_consts.svh ====
`ifndef SLAM_CB_CONSTS_SVH
`define SLAM_CB_CONSTS_SVH

// row geometry
`define CB_LANES 4       // banks per row, also A/B/M lane count
`define CB_DW 32         // signed covariance word

// bank geometry
`define CB_AW 6          // row address bits
`define CB_DEPTH (1 << `CB_AW)

// read sequence counter
`define CB_SEQ_DW 10

`endif

// ==== rtl/slam_cb_pkg.sv ====
`include "slam_cb_consts.svh"

package slam_cb_pkg;

  typedef logic signed [`CB_DW-1:0]          cb_word_t;
  typedef logic        [`CB_LANES*`CB_DW-1:0] cb_row_t;   // lane 0 in the low bits
  typedef logic        [`CB_AW-1:0]          cb_addr_t;
  typedef logic        [`CB_SEQ_DW-1:0]      cb_seq_t;
  typedef logic        [1:0]                 cb_bank_t;

  // where a row read goes
  typedef enum logic [2:0] {
    CB_DEST_IDLE = 3'b000,
    CB_DEST_A    = 3'b001,
    CB_DEST_B    = 3'b010,
    CB_DEST_M    = 3'b011,
    CB_DEST_TB   = 3'b100,
    CB_DEST_NL   = 3'b111
  } cb_dest_e;

  typedef enum logic [1:0] {
    CB_DIR_IDLE = 2'b00,
    CB_DIR_POS  = 2'b01,   // lanes as stored
    CB_DIR_NEG  = 2'b10,   // lanes flipped
    CB_DIR_NEW  = 2'b11    // new landmark, picked by l_k_0
  } cb_dir_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DRAIN
  } cb_seq_state_e;

endpackage

// ==== rtl/cb_bank_ram.sv ====
`timescale 1ns/100ps
`include "slam_cb_consts.svh"

module cb_bank_ram
  import slam_cb_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  input  logic     i_wr_en,
  input  cb_bank_t i_wr_bank,
  input  cb_addr_t i_wr_addr,
  input  cb_word_t i_wr_data,

  input  logic     i_rd_en,
  input  cb_addr_t i_rd_addr,
  output cb_row_t  o_rd_row
);

  for (genvar b = 0; b < `CB_LANES; b++) begin : g_bank

    cb_word_t mem [`CB_DEPTH];
    cb_word_t rd_q;

    // only the addressed bank takes the word
    always_ff @(posedge clk) begin
      if (i_wr_en && (i_wr_bank == cb_bank_t'(b))) begin
        mem[i_wr_addr] <= i_wr_data;
      end
    end

    // all banks read the same row address
    always_ff @(posedge clk) begin
      if (sys_rst) begin
        rd_q <= '0;
      end else if (i_rd_en) begin
        rd_q <= mem[i_rd_addr];
      end
    end

    assign o_rd_row[b*`CB_DW +: `CB_DW] = rd_q;   // bank b drives lane b

  end

endmodule

// ==== rtl/cb_read_seq.sv ====
`timescale 1ns/100ps
`include "slam_cb_consts.svh"

module cb_read_seq
  import slam_cb_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  input  logic     i_start,
  input  cb_dest_e i_dest,
  input  cb_dir_e  i_dir,
  input  logic     i_l_k_0,
  input  cb_addr_t i_base_addr,
  input  cb_seq_t  i_len,

  output logic     o_rd_en,
  output cb_addr_t o_rd_addr,

  output cb_dest_e o_dest,
  output cb_dir_e  o_dir,
  output logic     o_l_k_0,
  output cb_seq_t  o_seq_cnt,

  output logic     o_busy,
  output logic     o_done
);

  cb_seq_state_e state;
  cb_seq_t       len_q;
  cb_dest_e      dest_q;
  cb_dir_e       dir_q;
  logic          l_k_0_q;
  logic          drain_q;   // set in the second drain cycle

  // command latch, only taken while idle
  always_ff @(posedge clk) begin
    if ((state == SEQ_IDLE) && i_start) begin
      len_q   <= i_len;
      dest_q  <= i_dest;
      dir_q   <= i_dir;
      l_k_0_q <= i_l_k_0;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= SEQ_IDLE;
      o_rd_en   <= 1'b0;
      o_rd_addr <= '0;
      o_seq_cnt <= '0;
      drain_q   <= 1'b0;
      o_busy    <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (i_start) begin
            o_rd_en   <= (i_len != '0);   // empty command issues nothing
            o_rd_addr <= i_base_addr;
            o_seq_cnt <= '0;
            drain_q   <= 1'b0;
            o_busy    <= 1'b1;
            state     <= (i_len != '0) ? SEQ_RUN : SEQ_DRAIN;
          end
        end
        SEQ_RUN: begin
          o_seq_cnt <= o_seq_cnt + 1'b1;   // runs one past the last issue
          o_rd_addr <= o_rd_addr + 1'b1;
          if (o_seq_cnt == len_q - 1'b1) begin
            o_rd_en <= 1'b0;
            state   <= SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: begin
          // bank read plus mapper register
          drain_q <= 1'b1;
          if (drain_q) begin
            o_busy <= 1'b0;
            o_done <= 1'b1;
            state  <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // selector lines up with bank read data
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_dest  <= CB_DEST_IDLE;
      o_dir   <= CB_DIR_IDLE;
      o_l_k_0 <= 1'b0;
    end else begin
      o_dest  <= (state == SEQ_RUN) ? dest_q : CB_DEST_IDLE;
      o_dir   <= (state == SEQ_RUN) ? dir_q : CB_DIR_IDLE;
      o_l_k_0 <= l_k_0_q;
    end
  end

endmodule

// ==== rtl/cb_douta_map.sv ====
`timescale 1ns/100ps
`include "slam_cb_consts.svh"

module cb_douta_map
  import slam_cb_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  input  cb_dest_e i_dest,
  input  cb_dir_e  i_dir,
  input  logic     i_l_k_0,
  input  cb_seq_t  i_seq_cnt,   // leads the row by one
  input  cb_row_t  i_cb_douta,

  output cb_row_t  o_a_row,
  output cb_row_t  o_b_row,
  output cb_row_t  o_m_row,
  output cb_row_t  o_tb_row,

  output cb_word_t o_xk,
  output cb_word_t o_yk,
  output cb_word_t o_xita,
  output cb_word_t o_lkx,
  output cb_word_t o_lky
);

  cb_word_t in_lane [`CB_LANES];
  cb_word_t sel_lo;   // landmark x, lane 0 or 2
  cb_word_t sel_hi;   // landmark y, lane 1 or 3
  cb_row_t  op_row;
  cb_row_t  tb_row;
  cb_seq_t  seq_d;    // count matching the current row

  always_comb begin
    for (int i = 0; i < `CB_LANES; i++) begin
      in_lane[i] = i_cb_douta[i*`CB_DW +: `CB_DW];
    end
  end

  assign sel_lo = i_l_k_0 ? in_lane[0] : in_lane[2];
  assign sel_hi = i_l_k_0 ? in_lane[1] : in_lane[3];

  // operand lane mapping, shared by A, B and M
  always_comb begin
    op_row = '0;
    case (i_dir)
      CB_DIR_POS: op_row = i_cb_douta;
      CB_DIR_NEG: begin
        for (int i = 0; i < `CB_LANES; i++) begin
          op_row[i*`CB_DW +: `CB_DW] = in_lane[`CB_LANES-1-i];
        end
      end
      CB_DIR_NEW: begin
        op_row[0      +: `CB_DW] = sel_lo;
        op_row[`CB_DW +: `CB_DW] = sel_hi;   // upper two lanes stay zero
      end
      default: op_row = '0;
    endcase
  end

  // temp buffer placement of the (y, x) pair by row count
  always_comb begin
    tb_row = '0;
    if (i_dir == CB_DIR_NEW) begin
      case (seq_d)
        'd0: tb_row[3*`CB_DW +: `CB_DW] = sel_hi;
        'd1: tb_row[0        +: `CB_DW] = sel_lo;
        'd2: begin
          tb_row[0        +: `CB_DW] = sel_hi;
          tb_row[1*`CB_DW +: `CB_DW] = sel_lo;
        end
        'd3: begin
          tb_row[1*`CB_DW +: `CB_DW] = sel_hi;
          tb_row[2*`CB_DW +: `CB_DW] = sel_lo;
        end
        'd4: begin
          tb_row[2*`CB_DW +: `CB_DW] = sel_hi;
          tb_row[3*`CB_DW +: `CB_DW] = sel_lo;
        end
        default: tb_row = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      seq_d    <= '0;
      o_a_row  <= '0;
      o_b_row  <= '0;
      o_m_row  <= '0;
      o_tb_row <= '0;
    end else begin
      seq_d    <= i_seq_cnt;
      o_a_row  <= (i_dest == CB_DEST_A)  ? op_row : '0;
      o_b_row  <= (i_dest == CB_DEST_B)  ? op_row : '0;
      o_m_row  <= (i_dest == CB_DEST_M)  ? op_row : '0;
      o_tb_row <= (i_dest == CB_DEST_TB) ? tb_row : '0;
    end
  end

  // nonlinear scalars, held while the NL read lasts
  always_ff @(posedge clk) begin
    if (sys_rst || (i_dest != CB_DEST_NL)) begin
      o_xk   <= '0;
      o_yk   <= '0;
      o_xita <= '0;
      o_lkx  <= '0;
      o_lky  <= '0;
    end else begin
      case (i_seq_cnt)
        'd3: o_xk <= in_lane[0];
        'd4: begin
          o_yk  <= in_lane[1];
          o_lkx <= sel_lo;
        end
        'd5: begin
          o_xita <= in_lane[2];
          o_lky  <= sel_hi;
        end
        default: ;   // hold
      endcase
    end
  end

endmodule

// ==== rtl/cb_read_top.sv ====
`timescale 1ns/100ps
`include "slam_cb_consts.svh"

module cb_read_top
  import slam_cb_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  input  logic     i_wr_en,
  input  cb_bank_t i_wr_bank,
  input  cb_addr_t i_wr_addr,
  input  cb_word_t i_wr_data,

  input  logic     i_start,
  input  cb_dest_e i_dest,
  input  cb_dir_e  i_dir,
  input  logic     i_l_k_0,
  input  cb_addr_t i_base_addr,
  input  cb_seq_t  i_len,

  output logic     o_busy,
  output logic     o_done,

  output cb_row_t  o_a_row,
  output cb_row_t  o_b_row,
  output cb_row_t  o_m_row,
  output cb_row_t  o_tb_row,
  output cb_word_t o_xk,
  output cb_word_t o_yk,
  output cb_word_t o_xita,
  output cb_word_t o_lkx,
  output cb_word_t o_lky
);

  logic     rd_en;
  cb_addr_t rd_addr;
  cb_dest_e map_dest;   // already delayed to match the bank
  cb_dir_e  map_dir;
  logic     map_l_k_0;
  cb_seq_t  seq_cnt;
  cb_row_t  cb_douta;

  cb_read_seq cb_read_seq_inst (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_start     (i_start),
    .i_dest      (i_dest),
    .i_dir       (i_dir),
    .i_l_k_0     (i_l_k_0),
    .i_base_addr (i_base_addr),
    .i_len       (i_len),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .o_dest      (map_dest),
    .o_dir       (map_dir),
    .o_l_k_0     (map_l_k_0),
    .o_seq_cnt   (seq_cnt),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  cb_bank_ram cb_bank_ram_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_wr_en   (i_wr_en),
    .i_wr_bank (i_wr_bank),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_row  (cb_douta)
  );

  cb_douta_map cb_douta_map_inst (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_dest     (map_dest),
    .i_dir      (map_dir),
    .i_l_k_0    (map_l_k_0),
    .i_seq_cnt  (seq_cnt),
    .i_cb_douta (cb_douta),
    .o_a_row    (o_a_row),
    .o_b_row    (o_b_row),
    .o_m_row    (o_m_row),
    .o_tb_row   (o_tb_row),
    .o_xk       (o_xk),
    .o_yk       (o_yk),
    .o_xita     (o_xita),
    .o_lkx      (o_lkx),
    .o_lky      (o_lky)
  );

endmodule

// ==== tests/cb_read_properties.sv ====
`timescale 1ns/100ps

module cb_read_properties
  import slam_cb_pkg::*;
(
  input logic     clk,
  input logic     sys_rst,
  input logic     i_start,
  input cb_dest_e i_dest,
  input cb_dir_e  i_dir,
  input logic     i_l_k_0,
  input cb_addr_t i_base_addr,
  input cb_seq_t  i_len,
  input logic     o_busy,
  input logic     o_done,
  input cb_row_t  o_a_row,
  input cb_row_t  o_b_row,
  input cb_row_t  o_m_row,
  input cb_row_t  o_tb_row,
  input cb_word_t o_xk,
  input cb_word_t o_yk,
  input cb_word_t o_xita,
  input cb_word_t o_lkx,
  input cb_word_t o_lky
);

  localparam int W = $bits(cb_word_t);
  localparam int LANES = $bits(cb_row_t) / W;

  logic     active;
  int       t;        // clocks since the accepted start
  cb_dest_e c_dest;
  cb_dir_e  c_dir;
  logic     c_lk;
  cb_addr_t c_base;
  int       c_len;
  int       k;        // row index due at the outputs now
  logic     in_win;
  logic     nl_on;
  cb_addr_t row_a;
  cb_row_t  exp_op;
  cb_row_t  exp_tb;
  cb_word_t exp_xk;
  cb_word_t exp_yk;
  cb_word_t exp_xita;
  cb_word_t exp_lkx;
  cb_word_t exp_lky;
  int       fail_cnt = 0;

  // bank b at address a holds a*16 + b
  function automatic cb_word_t fill(cb_addr_t a, int b);
    return cb_word_t'(int'(a) * 16 + b);
  endfunction

  function automatic cb_row_t op_expect(cb_dir_e dir, logic lk, cb_addr_t a);
    cb_row_t r;
    r = '0;
    for (int i = 0; i < LANES; i++) begin
      if (dir == CB_DIR_POS) r[i*W +: W] = fill(a, i);
      if (dir == CB_DIR_NEG) r[i*W +: W] = fill(a, LANES - 1 - i);
    end
    if (dir == CB_DIR_NEW) begin
      r[0 +: W] = fill(a, lk ? 0 : 2);   // landmark x
      r[W +: W] = fill(a, lk ? 1 : 3);   // landmark y
    end
    return r;
  endfunction

  // pair (p, q) slides up one lane per row
  function automatic cb_row_t tb_expect(logic lk, cb_addr_t a, int n);
    cb_word_t p;
    cb_word_t q;
    cb_row_t  r;
    p = fill(a, lk ? 1 : 3);
    q = fill(a, lk ? 0 : 2);
    r = '0;
    if (n == 0) r[3*W +: W] = p;
    if (n == 1) r[0 +: W] = q;
    if (n >= 2 && n <= 4) begin
      r[(n-2)*W +: W] = p;
      r[(n-1)*W +: W] = q;
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      active <= 1'b0;
      t      <= 0;
      c_dest <= CB_DEST_IDLE;
      c_dir  <= CB_DIR_IDLE;
      c_lk   <= 1'b0;
      c_base <= '0;
      c_len  <= 0;
    end else if (i_start && !o_busy) begin
      active <= 1'b1;
      t      <= 1;
      c_dest <= i_dest;
      c_dir  <= i_dir;
      c_lk   <= i_l_k_0;
      c_base <= i_base_addr;
      c_len  <= int'(i_len);
    end else if (active) begin
      t <= t + 1;
      if (t == c_len + 3) active <= 1'b0;   // done cycle reached
    end
  end

  always_comb begin
    k        = t - 3;
    in_win   = active && (k >= 0) && (k < c_len);
    nl_on    = in_win && (c_dest == CB_DEST_NL);
    row_a    = c_base + cb_addr_t'(k);
    exp_op   = in_win ? op_expect(c_dir, c_lk, row_a) : '0;
    exp_tb   = (in_win && c_dir == CB_DIR_NEW) ? tb_expect(c_lk, row_a, k) : '0;
    exp_xk   = (nl_on && k >= 2) ? fill(c_base + 2, 0) : '0;
    exp_yk   = (nl_on && k >= 3) ? fill(c_base + 3, 1) : '0;
    exp_lkx  = (nl_on && k >= 3) ? fill(c_base + 3, c_lk ? 0 : 2) : '0;
    exp_xita = (nl_on && k >= 4) ? fill(c_base + 4, 2) : '0;
    exp_lky  = (nl_on && k >= 4) ? fill(c_base + 4, c_lk ? 1 : 3) : '0;
  end

  a_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_a_row == ((c_dest == CB_DEST_A) ? exp_op : '0))
    else begin
      fail_cnt++;
      $error("error at %0t: o_a_row %h, expected %h", $time, $sampled(o_a_row),
             $sampled(exp_op));
    end

  b_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_b_row == ((c_dest == CB_DEST_B) ? exp_op : '0))
    else begin
      fail_cnt++;
      $error("error at %0t: o_b_row %h, expected %h", $time, $sampled(o_b_row),
             $sampled(exp_op));
    end

  m_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_m_row == ((c_dest == CB_DEST_M) ? exp_op : '0))
    else begin
      fail_cnt++;
      $error("error at %0t: o_m_row %h, expected %h", $time, $sampled(o_m_row),
             $sampled(exp_op));
    end

  tb_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_tb_row == ((c_dest == CB_DEST_TB) ? exp_tb : '0))
    else begin
      fail_cnt++;
      $error("error at %0t: o_tb_row %h, expected %h", $time, $sampled(o_tb_row),
             $sampled(exp_tb));
    end

  nl_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_xk == exp_xk && o_yk == exp_yk && o_xita == exp_xita
    && o_lkx == exp_lkx && o_lky == exp_lky)
    else begin
      fail_cnt++;
      $error("error at %0t: nonlinear scalars differ from the rows read", $time);
    end

  busy_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_busy == (active && t <= c_len + 2))
    else begin
      fail_cnt++;
      $error("error at %0t: o_busy is %b", $time, $sampled(o_busy));
    end

  done_check: assert property (@(posedge clk) disable iff (sys_rst)
    o_done == (active && t == c_len + 3))
    else begin
      fail_cnt++;
      $error("error at %0t: o_done is %b", $time, $sampled(o_done));
    end

endmodule

bind cb_read_top cb_read_properties cb_read_properties_inst (.*);

// ==== tests/cb_read_tb.sv ====
`timescale 1ns/100ps
`include "slam_cb_consts.svh"

module cb_read_tb
  import slam_cb_pkg::*;
();

  logic     clk;
  logic     sys_rst;
  logic     wr_en;
  cb_bank_t wr_bank;
  cb_addr_t wr_addr;
  cb_word_t wr_data;
  logic     start;
  cb_dest_e dest;
  cb_dir_e  dir;
  logic     l_k_0;
  cb_addr_t base_addr;
  cb_seq_t  len;
  logic     busy;
  logic     done;
  cb_row_t  a_row;
  cb_row_t  b_row;
  cb_row_t  m_row;
  cb_row_t  tb_row;
  cb_word_t xk;
  cb_word_t yk;
  cb_word_t xita;
  cb_word_t lkx;
  cb_word_t lky;
  int       timeouts;
  int       fails;
  logic     lk_r;

  cb_read_top cb_read_top_inst (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_wr_en     (wr_en),
    .i_wr_bank   (wr_bank),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data),
    .i_start     (start),
    .i_dest      (dest),
    .i_dir       (dir),
    .i_l_k_0     (l_k_0),
    .i_base_addr (base_addr),
    .i_len       (len),
    .o_busy      (busy),
    .o_done      (done),
    .o_a_row     (a_row),
    .o_b_row     (b_row),
    .o_m_row     (m_row),
    .o_tb_row    (tb_row),
    .o_xk        (xk),
    .o_yk        (yk),
    .o_xita      (xita),
    .o_lkx       (lkx),
    .o_lky       (lky)
  );

  always #10 clk = ~clk;

  function automatic cb_addr_t rand_base();
    return cb_addr_t'($urandom % 56);   // keeps short reads below the top row
  endfunction

  task automatic fill_banks();
    for (int a = 0; a < `CB_DEPTH; a++) begin
      for (int b = 0; b < `CB_LANES; b++) begin
        @(negedge clk);
        wr_en   = 1'b1;
        wr_bank = cb_bank_t'(b);
        wr_addr = cb_addr_t'(a);
        wr_data = cb_word_t'(a * 16 + b);   // lane b of row a
      end
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic issue_cmd(cb_dest_e d, cb_dir_e r, logic lk, cb_addr_t base, int n);
    @(negedge clk);
    start     = 1'b1;
    dest      = d;
    dir       = r;
    l_k_0     = lk;
    base_addr = base;
    len       = cb_seq_t'(n);
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done(int limit);
    int n;
    n = 0;
    while (!done && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("timeout at %0t: the read command never completed", $time);
      timeouts++;
    end
  endtask

  task automatic run_cmd(cb_dest_e d, cb_dir_e r, logic lk, cb_addr_t base, int n);
    issue_cmd(d, r, lk, base, n);
    wait_done(n + 20);
  endtask

  initial begin
    void'($urandom(73288));
    clk       = 1'b0;
    sys_rst   = 1'b1;
    wr_en     = 1'b0;
    wr_bank   = '0;
    wr_addr   = '0;
    wr_data   = '0;
    start     = 1'b0;
    dest      = CB_DEST_IDLE;
    dir       = CB_DIR_IDLE;
    l_k_0     = 1'b0;
    base_addr = '0;
    len       = '0;
    timeouts  = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    sys_rst = 1'b0;

    fill_banks();

    // operand ports A, B, M in every lane mapping
    for (int d = 1; d <= 3; d++) begin
      run_cmd(cb_dest_e'(d), CB_DIR_POS, 1'b0, rand_base(), 4);
      run_cmd(cb_dest_e'(d), CB_DIR_NEG, 1'b0, rand_base(), 4);
      run_cmd(cb_dest_e'(d), CB_DIR_NEW, 1'b1, rand_base(), 3);
      run_cmd(cb_dest_e'(d), CB_DIR_NEW, 1'b0, rand_base(), 3);
    end

    lk_r = ($urandom % 2) != 0;
    run_cmd(CB_DEST_TB, CB_DIR_NEW, lk_r, rand_base(), 5);
    run_cmd(CB_DEST_TB, CB_DIR_NEW, !lk_r, rand_base(), 5);
    run_cmd(CB_DEST_NL, CB_DIR_NEW, lk_r, rand_base(), 6);
    run_cmd(CB_DEST_NL, CB_DIR_NEW, !lk_r, rand_base(), 8);
    run_cmd(CB_DEST_A, CB_DIR_POS, 1'b0, rand_base(), 0);   // empty read

    // second start lands while the first read is busy
    issue_cmd(CB_DEST_B, CB_DIR_POS, 1'b0, rand_base(), 8);
    repeat (3) @(negedge clk);
    issue_cmd(CB_DEST_A, CB_DIR_NEG, 1'b1, rand_base(), 4);
    wait_done(40);

    repeat (8) @(negedge clk);
    fails = cb_read_top_inst.cb_read_properties_inst.fail_cnt;
    $display("errors: %0d assertion failures, %0d timeouts", fails, timeouts);
    if ((fails == 0) && (timeouts == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== slam_cb.f ====
+incdir+rtl
rtl/slam_cb_pkg.sv
rtl/cb_bank_ram.sv
rtl/cb_read_seq.sv
rtl/cb_douta_map.sv
rtl/cb_read_top.sv
tests/cb_read_properties.sv
tests/cb_read_tb.sv

// ==== Bender.yml ====
package:
  name: slam_cb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/slam_cb_pkg.sv
      - rtl/cb_bank_ram.sv
      - rtl/cb_read_seq.sv
      - rtl/cb_douta_map.sv
      - rtl/cb_read_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/cb_read_properties.sv
      - tests/cb_read_tb.sv
